// ==== Makefile ====
# Verilator build for the out-of-order ALU cluster testbench

VERILATOR ?= verilator
TOP       ?= tb_ooo_alu_cluster
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= ^Test passed$$

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# output goes to the terminal, the status comes from the search
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== compile.f ====
+incdir+src
src/ooo_pkg.sv
src/rs_slot_if.sv
src/phys_reg_file.sv
src/dispatch_unit.sv
src/rs_slot.sv
src/issue_execute.sv
src/ooo_alu_cluster.sv
tests/tb_clock_gen.sv
tests/tb_ooo_alu_cluster.sv

// ==== src/dispatch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ooo_cfg.svh"

module dispatch_unit (
    input  logic              dispatch_valid,
    input  ooo_pkg::alu_op_t  dispatch_op,
    input  ooo_pkg::phy_t     dispatch_rd,
    input  ooo_pkg::xlen_t    dispatch_imm,
    input  logic              dispatch_use_imm,
    input  ooo_pkg::xlen_t    val1,
    input  ooo_pkg::xlen_t    val2,
    input  logic              rdy1,
    input  logic              rdy2,
    input  ooo_pkg::phy_t     dispatch_src1,
    input  ooo_pkg::phy_t     dispatch_src2,
    rs_slot_if.dispatch       slots [`OOO_RS_DEPTH],
    output logic              rs_full
);

    logic [`OOO_RS_DEPTH-1:0] busy_vec;
    logic [`OOO_RS_DEPTH-1:0] free_vec;
    logic [`OOO_RS_DEPTH-1:0] alloc_vec;
    ooo_pkg::rs_payload_t     entry;

    assign free_vec = ~busy_vec;
    // lowest free slot only
    assign alloc_vec = dispatch_valid ? (free_vec & (~free_vec + 1'b1)) : '0;
    assign rs_full = &busy_vec;

    always_comb begin
        entry.op   = dispatch_op;
        entry.rd   = dispatch_rd;
        entry.src1 = dispatch_src1;
        entry.src2 = dispatch_src2;
        entry.val1 = val1;
        entry.rdy1 = rdy1;
        if (dispatch_use_imm) begin
            entry.val2 = dispatch_imm;
            entry.rdy2 = 1'b1;   // immediate never waits
        end else begin
            entry.val2 = val2;
            entry.rdy2 = rdy2;
        end
    end

    for (genvar i = 0; i < `OOO_RS_DEPTH; i++) begin : g_slot
        assign busy_vec[i]      = slots[i].busy;
        assign slots[i].alloc   = alloc_vec[i];
        assign slots[i].payload = entry;
    end

endmodule

`default_nettype wire

// ==== src/issue_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ooo_cfg.svh"

module issue_execute (
    input  logic                 clk,
    input  logic                 reset,
    rs_slot_if.issue             slots [`OOO_RS_DEPTH],
    output ooo_pkg::result_bus_t alu_bus
);

    logic [`OOO_RS_DEPTH-1:0] req_vec;
    logic [`OOO_RS_DEPTH-1:0] grant_vec;
    ooo_pkg::rs_payload_t     slot_pl [`OOO_RS_DEPTH];
    ooo_pkg::rs_payload_t     sel_pl;

    logic                     ex_valid;
    ooo_pkg::alu_op_t         ex_op;
    ooo_pkg::phy_t            ex_rd;
    ooo_pkg::xlen_t           ex_a;
    ooo_pkg::xlen_t           ex_b;
    ooo_pkg::xlen_t           alu_res;

    for (genvar i = 0; i < `OOO_RS_DEPTH; i++) begin : g_slot
        assign req_vec[i]     = slots[i].request;
        assign slot_pl[i]     = slots[i].issue_payload;
        assign slots[i].grant = grant_vec[i];
    end

    assign grant_vec = req_vec & (~req_vec + 1'b1);   // lowest index wins

    always_comb begin
        sel_pl = slot_pl[0];
        for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
            if (grant_vec[i])
                sel_pl = slot_pl[i];
        end
    end

    // execute register
    always_ff @(posedge clk) begin
        if (reset)
            ex_valid <= 1'b0;
        else
            ex_valid <= |req_vec;
    end

    always_ff @(posedge clk) begin
        ex_op <= sel_pl.op;
        ex_rd <= sel_pl.rd;
        ex_a  <= sel_pl.val1;
        ex_b  <= sel_pl.val2;
    end

    always_comb begin
        case (ex_op)
            ooo_pkg::ALU_ADD:  alu_res = ex_a + ex_b;
            ooo_pkg::ALU_SUB:  alu_res = ex_a - ex_b;
            ooo_pkg::ALU_AND:  alu_res = ex_a & ex_b;
            ooo_pkg::ALU_OR:   alu_res = ex_a | ex_b;
            ooo_pkg::ALU_XOR:  alu_res = ex_a ^ ex_b;
            ooo_pkg::ALU_SLL:  alu_res = ex_a << ex_b[4:0];
            ooo_pkg::ALU_SRL:  alu_res = ex_a >> ex_b[4:0];
            ooo_pkg::ALU_SRA:  alu_res = $signed(ex_a) >>> ex_b[4:0];
            ooo_pkg::ALU_SLT:  alu_res = {{(`OOO_XLEN-1){1'b0}}, $signed(ex_a) < $signed(ex_b)};
            ooo_pkg::ALU_SLTU: alu_res = {{(`OOO_XLEN-1){1'b0}}, ex_a < ex_b};
            default:           alu_res = '0;
        endcase
    end

    // result bus register
    always_ff @(posedge clk) begin
        if (reset)
            alu_bus.valid <= 1'b0;
        else
            alu_bus.valid <= ex_valid;
    end

    always_ff @(posedge clk) begin
        alu_bus.phy  <= ex_rd;
        alu_bus.data <= alu_res;
    end

endmodule

`default_nettype wire

// ==== src/ooo_alu_cluster.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ooo_cfg.svh"

module ooo_alu_cluster (
    input  logic             clk,
    input  logic             reset,
    input  logic             dispatch_valid,
    input  ooo_pkg::alu_op_t dispatch_op,
    input  ooo_pkg::phy_t    dispatch_rd,
    input  ooo_pkg::phy_t    dispatch_src1,
    input  ooo_pkg::phy_t    dispatch_src2,
    input  ooo_pkg::xlen_t   dispatch_imm,
    input  logic             dispatch_use_imm,
    input  logic             load_alloc_valid,
    input  ooo_pkg::phy_t    load_alloc_phy,
    input  logic             load_return_valid,
    input  ooo_pkg::phy_t    load_return_phy,
    input  ooo_pkg::xlen_t   load_return_data,
    output logic             rs_full,
    output logic             result_valid,
    output ooo_pkg::phy_t    result_phy,
    output ooo_pkg::xlen_t   result_data
);

    ooo_pkg::result_bus_t alu_bus;
    ooo_pkg::result_bus_t load_bus;
    ooo_pkg::xlen_t       rf_val1;
    ooo_pkg::xlen_t       rf_val2;
    logic                 rf_rdy1;
    logic                 rf_rdy2;

    rs_slot_if slot_bus [`OOO_RS_DEPTH] ();

    assign load_bus = {load_return_valid, load_return_phy, load_return_data};

    assign result_valid = alu_bus.valid;
    assign result_phy   = alu_bus.phy;
    assign result_data  = alu_bus.data;

    phys_reg_file u_prf (
        .clk              (clk),
        .reset            (reset),
        .src1             (dispatch_src1),
        .src2             (dispatch_src2),
        .val1             (rf_val1),
        .val2             (rf_val2),
        .rdy1             (rf_rdy1),
        .rdy2             (rf_rdy2),
        .clear_valid      (dispatch_valid),
        .clear_phy        (dispatch_rd),
        .load_clear_valid (load_alloc_valid),
        .load_clear_phy   (load_alloc_phy),
        .alu_bus          (alu_bus),
        .load_bus         (load_bus)
    );

    dispatch_unit u_dispatch (
        .dispatch_valid   (dispatch_valid),
        .dispatch_op      (dispatch_op),
        .dispatch_rd      (dispatch_rd),
        .dispatch_imm     (dispatch_imm),
        .dispatch_use_imm (dispatch_use_imm),
        .val1             (rf_val1),
        .val2             (rf_val2),
        .rdy1             (rf_rdy1),
        .rdy2             (rf_rdy2),
        .dispatch_src1    (dispatch_src1),
        .dispatch_src2    (dispatch_src2),
        .slots            (slot_bus),
        .rs_full          (rs_full)
    );

    for (genvar i = 0; i < `OOO_RS_DEPTH; i++) begin : g_rs
        rs_slot u_slot (
            .clk      (clk),
            .reset    (reset),
            .port     (slot_bus[i]),
            .alu_bus  (alu_bus),
            .load_bus (load_bus)
        );
    end

    issue_execute u_issue (
        .clk     (clk),
        .reset   (reset),
        .slots   (slot_bus),
        .alu_bus (alu_bus)
    );

endmodule

`default_nettype wire

// ==== src/ooo_cfg.svh ====
`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

// datapath width
`define OOO_XLEN 32

// physical register file
`define OOO_PHY_REGS 64
`define OOO_PHY_W 6

// reservation station entries
`define OOO_RS_DEPTH 8

`endif

// ==== src/ooo_pkg.sv ====
`default_nettype none

`include "ooo_cfg.svh"

package ooo_pkg;

    typedef logic [`OOO_XLEN-1:0] xlen_t;
    typedef logic [`OOO_PHY_W-1:0] phy_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_t;

    // shared by the alu result bus and the load return bus
    typedef struct packed {
        logic  valid;
        phy_t  phy;
        xlen_t data;
    } result_bus_t;

    typedef struct packed {
        alu_op_t op;
        phy_t    rd;
        phy_t    src1;
        phy_t    src2;
        xlen_t   val1;
        xlen_t   val2;   // holds the immediate when one is used
        logic    rdy1;
        logic    rdy2;
    } rs_payload_t;

endpackage

`default_nettype wire

// ==== src/phys_reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ooo_cfg.svh"

module phys_reg_file (
    input  logic                 clk,
    input  logic                 reset,
    input  ooo_pkg::phy_t        src1,
    input  ooo_pkg::phy_t        src2,
    output ooo_pkg::xlen_t       val1,
    output ooo_pkg::xlen_t       val2,
    output logic                 rdy1,
    output logic                 rdy2,
    input  logic                 clear_valid,
    input  ooo_pkg::phy_t        clear_phy,
    input  logic                 load_clear_valid,
    input  ooo_pkg::phy_t        load_clear_phy,
    input  ooo_pkg::result_bus_t alu_bus,
    input  ooo_pkg::result_bus_t load_bus
);

    ooo_pkg::xlen_t          regs [`OOO_PHY_REGS];
    logic [`OOO_PHY_REGS-1:0] ready;

    // returns {ready, value}, a matching bus wins over the stored word
    function automatic logic [`OOO_XLEN:0] read_operand(input ooo_pkg::phy_t tag);
        if (alu_bus.valid && alu_bus.phy == tag)
            return {1'b1, alu_bus.data};
        if (load_bus.valid && load_bus.phy == tag)
            return {1'b1, load_bus.data};
        return {ready[tag], regs[tag]};
    endfunction

    always_comb begin
        {rdy1, val1} = read_operand(src1);
        {rdy2, val2} = read_operand(src2);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `OOO_PHY_REGS; i++) begin
                regs[i] <= '0;   // every tag reads zero and ready
            end
            ready <= '1;
        end else begin
            if (alu_bus.valid) begin
                regs[alu_bus.phy]  <= alu_bus.data;
                ready[alu_bus.phy] <= 1'b1;
            end
            if (load_bus.valid) begin
                regs[load_bus.phy]  <= load_bus.data;
                ready[load_bus.phy] <= 1'b1;
            end
            // new producers, pending until their bus write
            if (clear_valid)
                ready[clear_phy] <= 1'b0;
            if (load_clear_valid)
                ready[load_clear_phy] <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== src/rs_slot.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_slot (
    input  logic                 clk,
    input  logic                 reset,
    rs_slot_if.slot              port,
    input  ooo_pkg::result_bus_t alu_bus,
    input  ooo_pkg::result_bus_t load_bus
);

    logic                 busy;
    ooo_pkg::rs_payload_t entry;
    logic                 hit1_alu;
    logic                 hit1_load;
    logic                 hit2_alu;
    logic                 hit2_load;

    // wakeup match, only for operands still pending
    assign hit1_alu  = !entry.rdy1 && alu_bus.valid && alu_bus.phy == entry.src1;
    assign hit1_load = !entry.rdy1 && load_bus.valid && load_bus.phy == entry.src1;
    assign hit2_alu  = !entry.rdy2 && alu_bus.valid && alu_bus.phy == entry.src2;
    assign hit2_load = !entry.rdy2 && load_bus.valid && load_bus.phy == entry.src2;

    always_ff @(posedge clk) begin
        if (reset)
            busy <= 1'b0;
        else if (port.alloc)
            busy <= 1'b1;
        else if (port.grant)
            busy <= 1'b0;   // free right after issue
    end

    always_ff @(posedge clk) begin
        if (port.alloc) begin
            entry <= port.payload;
        end else begin
            if (hit1_alu) begin
                entry.val1 <= alu_bus.data;
                entry.rdy1 <= 1'b1;
            end else if (hit1_load) begin
                entry.val1 <= load_bus.data;
                entry.rdy1 <= 1'b1;
            end
            if (hit2_alu) begin
                entry.val2 <= alu_bus.data;
                entry.rdy2 <= 1'b1;
            end else if (hit2_load) begin
                entry.val2 <= load_bus.data;
                entry.rdy2 <= 1'b1;
            end
        end
    end

    assign port.busy          = busy;
    assign port.request       = busy && entry.rdy1 && entry.rdy2;
    assign port.issue_payload = entry;

endmodule

`default_nettype wire

// ==== src/rs_slot_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface rs_slot_if;

    logic                 alloc;          // one-cycle strobe from dispatch
    ooo_pkg::rs_payload_t payload;
    logic                 busy;
    logic                 request;        // busy with both operands ready
    logic                 grant;          // one-hot across slots
    ooo_pkg::rs_payload_t issue_payload;

    modport dispatch (
        output alloc,
        output payload,
        input  busy
    );

    modport slot (
        input  alloc,
        input  payload,
        input  grant,
        output busy,
        output request,
        output issue_payload
    );

    modport issue (
        input  request,
        input  issue_payload,
        output grant
    );

endinterface

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== tests/tb_ooo_alu_cluster.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ooo_cfg.svh"

module tb_ooo_alu_cluster;

    localparam int test_cycles = 300;   // five tests summed, roughly

    logic             clk;
    logic             reset;
    logic             dispatch_valid;
    ooo_pkg::alu_op_t dispatch_op;
    ooo_pkg::phy_t    dispatch_rd;
    ooo_pkg::phy_t    dispatch_src1;
    ooo_pkg::phy_t    dispatch_src2;
    ooo_pkg::xlen_t   dispatch_imm;
    logic             dispatch_use_imm;
    logic             load_alloc_valid;
    ooo_pkg::phy_t    load_alloc_phy;
    logic             load_return_valid;
    ooo_pkg::phy_t    load_return_phy;
    ooo_pkg::xlen_t   load_return_data;
    logic             rs_full;
    logic             result_valid;
    ooo_pkg::phy_t    result_phy;
    ooo_pkg::xlen_t   result_data;

    ooo_pkg::xlen_t   model [`OOO_PHY_REGS];
    ooo_pkg::xlen_t   exp_val [`OOO_PHY_REGS];
    bit               exp_mask [`OOO_PHY_REGS];
    int               got_count [`OOO_PHY_REGS];
    ooo_pkg::xlen_t   got_data [`OOO_PHY_REGS];
    logic [31:0]      rng;
    int               errors;
    int               test_errors;
    int               checks;
    int               tests_run;

    tb_clock_gen u_clk (.clk(clk), .reset(reset));

    ooo_alu_cluster dut (.*);

    // results sampled before the edge updates them
    always @(posedge clk) begin
        if (!reset && result_valid) begin
            got_count[result_phy] = got_count[result_phy] + 1;
            got_data[result_phy]  = result_data;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic ooo_pkg::xlen_t alu_model(input ooo_pkg::alu_op_t op,
                                                 input ooo_pkg::xlen_t a,
                                                 input ooo_pkg::xlen_t b);
        case (op)
            ooo_pkg::ALU_ADD:  return a + b;
            ooo_pkg::ALU_SUB:  return a - b;
            ooo_pkg::ALU_AND:  return a & b;
            ooo_pkg::ALU_OR:   return a | b;
            ooo_pkg::ALU_XOR:  return a ^ b;
            ooo_pkg::ALU_SLL:  return a << b[4:0];
            ooo_pkg::ALU_SRL:  return a >> b[4:0];
            ooo_pkg::ALU_SRA:  return ooo_pkg::xlen_t'($signed(a) >>> b[4:0]);
            ooo_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ooo_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:           return '0;
        endcase
    endfunction

    task automatic report_problem(input string msg);
        $display("%s", msg);
        errors++;
        test_errors++;
    endtask

    task automatic check_data(input ooo_pkg::xlen_t got, input ooo_pkg::xlen_t exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            $display("error at %0d ns: %s got %h, expected %h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_phy(input ooo_pkg::phy_t got, input ooo_pkg::phy_t exp,
                             input string what);
        checks++;
        if (got !== exp) begin
            $display("error at %0d ns: %s got %0d, expected %0d", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic clear_results();
        for (int t = 0; t < `OOO_PHY_REGS; t++) begin
            got_count[t] = 0;
            exp_mask[t]  = 1'b0;
        end
    endtask

    // one edge; strobes drop unless the caller raises them again
    task automatic step();
        @(posedge clk);
        dispatch_valid    <= 1'b0;
        load_alloc_valid  <= 1'b0;
        load_return_valid <= 1'b0;
    endtask

    task automatic send_op(input ooo_pkg::alu_op_t op, input ooo_pkg::phy_t rd,
                           input ooo_pkg::phy_t s1, input ooo_pkg::phy_t s2,
                           input logic use_imm, input ooo_pkg::xlen_t imm);
        model[rd]    = alu_model(op, model[s1], use_imm ? imm : model[s2]);
        exp_val[rd]  = model[rd];
        exp_mask[rd] = 1'b1;
        step();
        dispatch_valid   <= 1'b1;
        dispatch_op      <= op;
        dispatch_rd      <= rd;
        dispatch_src1    <= s1;
        dispatch_src2    <= s2;
        dispatch_use_imm <= use_imm;
        dispatch_imm     <= imm;
    endtask

    task automatic alloc_load(input ooo_pkg::phy_t tag, input ooo_pkg::xlen_t data);
        model[tag] = data;   // value the load brings back later
        step();
        load_alloc_valid <= 1'b1;
        load_alloc_phy   <= tag;
    endtask

    task automatic return_load(input ooo_pkg::phy_t tag);
        step();
        load_return_valid <= 1'b1;
        load_return_phy   <= tag;
        load_return_data  <= model[tag];
    endtask

    task automatic set_reg(input ooo_pkg::phy_t tag, input ooo_pkg::xlen_t data);
        alloc_load(tag, data);
        return_load(tag);
    endtask

    task automatic wait_result(input ooo_pkg::phy_t tag);
        int n;
        n = 0;
        while (got_count[tag] == 0 && n < 40) begin
            @(negedge clk);
            n++;
        end
        if (got_count[tag] == 0)
            report_problem($sformatf("no result ever arrived for tag %0d", tag));
        else
            check_data(got_data[tag], exp_val[tag], $sformatf("data of tag %0d", tag));
    endtask

    task automatic close_test(input string name);
        repeat (6) @(negedge clk);
        for (int t = 0; t < `OOO_PHY_REGS; t++) begin
            if (got_count[t] != int'(exp_mask[t]))
                report_problem($sformatf("tag %0d gave %0d results instead of %0d",
                                         t, got_count[t], int'(exp_mask[t])));
        end
        tests_run++;
        $display("%-12s %0d errors", name, test_errors);
        test_errors = 0;
        clear_results();
    endtask

    task automatic test_reset_add();
        if (result_valid !== 1'b0 || rs_full !== 1'b0)
            report_problem("result_valid or rs_full is high after reset");
        send_op(ooo_pkg::ALU_ADD, 6'd10, 6'd3, 6'd4, 1'b0, '0);   // reset regs read zero
        step();
        wait_result(6'd10);
        set_reg(6'd1, 32'd1234);
        set_reg(6'd2, 32'hffff_0001);
        send_op(ooo_pkg::ALU_ADD, 6'd11, 6'd1, 6'd2, 1'b0, '0);
        step();   // dispatch edge
        repeat (2) begin
            @(negedge clk);
            if (result_valid)
                report_problem("result_valid rose before two cycles had passed");
        end
        @(negedge clk);
        if (result_valid !== 1'b1) begin
            report_problem("no result two cycles after the dispatch edge");
        end else begin
            check_phy(result_phy, 6'd11, "tag of single add");
            check_data(result_data, exp_val[11], "data of single add");
        end
        close_test("reset_add");
    endtask

    task automatic test_all_ops();
        ooo_pkg::alu_op_t op;
        for (int i = 0; i < 10; i++) begin
            op = ooo_pkg::alu_op_t'(i);
            rng = xorshift(rng);
            set_reg(6'd1, rng);
            rng = xorshift(rng);
            set_reg(6'd2, rng);
            rng = xorshift(rng);
            send_op(op, ooo_pkg::phy_t'(12 + i), 6'd1, 6'd2, 1'b0, '0);
            send_op(op, ooo_pkg::phy_t'(32 + i), 6'd1, 6'd2, 1'b1, rng);   // immediate form
        end
        step();
        for (int i = 0; i < 10; i++) begin
            wait_result(ooo_pkg::phy_t'(12 + i));
            wait_result(ooo_pkg::phy_t'(32 + i));
        end
        close_test("all_ops");
    endtask

    task automatic test_chain();
        rng = xorshift(rng);
        set_reg(6'd3, rng);
        rng = xorshift(rng);
        set_reg(6'd4, rng);
        rng = xorshift(rng);
        send_op(ooo_pkg::ALU_ADD, 6'd20, 6'd3, 6'd4, 1'b0, '0);
        send_op(ooo_pkg::ALU_XOR, 6'd21, 6'd20, 6'd4, 1'b0, '0);
        send_op(ooo_pkg::ALU_SLL, 6'd22, 6'd21, 6'd0, 1'b1, rng);
        send_op(ooo_pkg::ALU_SUB, 6'd23, 6'd3, 6'd22, 1'b0, '0);
        send_op(ooo_pkg::ALU_SRA, 6'd24, 6'd23, 6'd0, 1'b1, rng >> 8);
        send_op(ooo_pkg::ALU_SLTU, 6'd25, 6'd24, 6'd20, 1'b0, '0);
        step();
        for (int t = 20; t < 26; t++)
            wait_result(ooo_pkg::phy_t'(t));
        // consumer dispatched while its producer is on the result bus
        send_op(ooo_pkg::ALU_OR, 6'd26, 6'd3, 6'd4, 1'b0, '0);
        step();
        step();
        send_op(ooo_pkg::ALU_ADD, 6'd27, 6'd26, 6'd26, 1'b0, '0);
        step();
        wait_result(6'd26);
        wait_result(6'd27);
        close_test("chain");
    endtask

    task automatic test_load_wait();
        rng = xorshift(rng);
        set_reg(6'd5, rng);
        rng = xorshift(rng);
        alloc_load(6'd40, rng);
        send_op(ooo_pkg::ALU_ADD, 6'd41, 6'd40, 6'd5, 1'b0, '0);
        send_op(ooo_pkg::ALU_AND, 6'd42, 6'd5, 6'd40, 1'b0, '0);
        step();
        repeat (10) @(negedge clk);
        if (got_count[41] != 0 || got_count[42] != 0)
            report_problem("a result arrived before its load returned");
        return_load(6'd40);
        step();
        wait_result(6'd41);
        wait_result(6'd42);
        // two loads, returned in reverse order
        rng = xorshift(rng);
        alloc_load(6'd43, rng);
        rng = xorshift(rng);
        alloc_load(6'd44, rng);
        send_op(ooo_pkg::ALU_SUB, 6'd45, 6'd43, 6'd5, 1'b0, '0);
        send_op(ooo_pkg::ALU_XOR, 6'd46, 6'd44, 6'd5, 1'b0, '0);
        send_op(ooo_pkg::ALU_ADD, 6'd47, 6'd43, 6'd44, 1'b0, '0);
        return_load(6'd44);
        step();
        wait_result(6'd46);
        if (got_count[45] != 0 || got_count[47] != 0)
            report_problem("an op waiting on the first load finished before it returned");
        return_load(6'd43);
        step();
        wait_result(6'd45);
        wait_result(6'd47);
        close_test("load_wait");
    endtask

    task automatic test_full();
        rng = xorshift(rng);
        set_reg(6'd6, rng);
        rng = xorshift(rng);
        alloc_load(6'd50, rng);
        for (int i = 0; i < `OOO_RS_DEPTH; i++)
            send_op(ooo_pkg::alu_op_t'(i), ooo_pkg::phy_t'(51 + i), 6'd50, 6'd6, 1'b0, '0);
        step();
        @(negedge clk);
        if (rs_full !== 1'b1)
            report_problem("rs_full stayed low with every slot waiting on a load");
        repeat (4) @(negedge clk);
        return_load(6'd50);
        step();
        for (int i = 0; i < `OOO_RS_DEPTH; i++)
            wait_result(ooo_pkg::phy_t'(51 + i));
        @(negedge clk);
        if (rs_full !== 1'b0)
            report_problem("rs_full stayed high after all slots drained");
        close_test("full");
    endtask

    initial begin
        #(2 * test_cycles * 8);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        dispatch_valid    = 1'b0;
        dispatch_op       = ooo_pkg::ALU_ADD;
        dispatch_rd       = '0;
        dispatch_src1     = '0;
        dispatch_src2     = '0;
        dispatch_imm      = '0;
        dispatch_use_imm  = 1'b0;
        load_alloc_valid  = 1'b0;
        load_alloc_phy    = '0;
        load_return_valid = 1'b0;
        load_return_phy   = '0;
        load_return_data  = '0;
        rng         = 32'hffd3;
        errors      = 0;
        test_errors = 0;
        checks      = 0;
        tests_run   = 0;
        for (int t = 0; t < `OOO_PHY_REGS; t++)
            model[t] = '0;
        clear_results();
        @(negedge clk);
        while (reset)
            @(negedge clk);
        test_reset_add();
        test_all_ops();
        test_chain();
        test_load_wait();
        test_full();
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
